// ==== verilog/engine_pkg.sv ====
`default_nettype none

package engine_pkg;

	localparam int SAMPLE_W = 16;
	localparam int ADDR_W = 30;
	localparam int SIDE_W = 8;
	localparam int KERN_W = 4;
	// Headroom for 15x15 full scale samples
	localparam int ACC_W = 24;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SIDE_W-1:0] side_t;
	typedef logic [KERN_W-1:0] kern_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// Saturation limits of a sample
	localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

	typedef enum logic {
		POOL_MAX = 1'b0,
		POOL_SUM = 1'b1
	} pool_op_e;

	typedef enum logic [2:0] {
		ST_IDLE   = 3'd0,
		ST_READ   = 3'd1,
		ST_WAIT   = 3'd2,
		ST_REDUCE = 3'd3,
		ST_WRITE  = 3'd4,
		ST_DONE   = 3'd5
	} ctrl_state_e;

	typedef struct packed {
		pool_op_e op;
		side_t    i_side;
		side_t    o_side;
		kern_t    kernel;
		kern_t    stride;
		addr_t    data_addr;
		addr_t    result_addr;
	} engine_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/engine_ctrl.sv ====
`default_nettype none

module engine_ctrl (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire                          i_start,
	input  wire engine_pkg::engine_cmd_t i_cmd,
	input  wire                          i_rd_we,
	input  wire                          i_kern_last,
	input  wire                          i_pos_last,
	input  wire                          i_res_taken,
	output engine_pkg::engine_cmd_t      o_cmd,
	output logic                         o_busy,
	output logic                         o_done,
	output logic                         o_rd_en,
	output logic                         o_cnt_clear,
	output logic                         o_kern_step,
	output logic                         o_pos_step,
	output logic                         o_acc_clear,
	output logic                         o_acc_load,
	output logic                         o_res_load
);

	engine_pkg::ctrl_state_e state_q;
	engine_pkg::ctrl_state_e state_d;
	logic start_ok;
	logic rd_resp;
	logic wr_done;

	assign start_ok = (state_q == engine_pkg::ST_IDLE) && i_start;
	assign rd_resp = (state_q == engine_pkg::ST_READ) && i_rd_we;
	assign wr_done = (state_q == engine_pkg::ST_WRITE) && i_res_taken;

	// Command is held for the whole run
	always_ff @(posedge clk) begin
		if (start_ok) begin
			o_cmd <= i_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= engine_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			engine_pkg::ST_IDLE: begin
				if (i_start) begin
					state_d = engine_pkg::ST_WAIT;
				end
			end
			engine_pkg::ST_WAIT: begin
				state_d = engine_pkg::ST_READ;
			end
			engine_pkg::ST_READ: begin
				if (i_rd_we) begin
					state_d = i_kern_last ? engine_pkg::ST_REDUCE : engine_pkg::ST_WAIT;
				end
			end
			engine_pkg::ST_REDUCE: begin
				state_d = engine_pkg::ST_WRITE;
			end
			engine_pkg::ST_WRITE: begin
				if (i_res_taken) begin
					state_d = i_pos_last ? engine_pkg::ST_DONE : engine_pkg::ST_READ;
				end
			end
			engine_pkg::ST_DONE: begin
				state_d = engine_pkg::ST_IDLE;
			end
			default: begin
				state_d = engine_pkg::ST_IDLE;
			end
		endcase
	end

	assign o_busy = state_q != engine_pkg::ST_IDLE;
	assign o_done = state_q == engine_pkg::ST_DONE;
	assign o_rd_en = state_q == engine_pkg::ST_READ;
	assign o_cnt_clear = start_ok;
	assign o_kern_step = rd_resp;
	assign o_acc_load = rd_resp;
	assign o_res_load = state_q == engine_pkg::ST_REDUCE;
	// Next window starts right after the write is accepted
	assign o_pos_step = wr_done && !i_pos_last;
	assign o_acc_clear = start_ok || wr_done;

	a_no_start_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_busy |-> !i_start);

	// Read request is still up when the DMA answers
	a_rd_resp: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_rd_we |-> o_rd_en);

endmodule

`default_nettype wire

// ==== verilog/window_counter.sv ====
`default_nettype none

module window_counter (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire engine_pkg::engine_cmd_t i_cmd,
	input  wire                          i_clear,
	input  wire                          i_kern_step,
	input  wire                          i_pos_step,
	output logic                         o_kern_last,
	output logic                         o_pos_last,
	output engine_pkg::addr_t            o_rd_addr,
	output engine_pkg::addr_t            o_wr_addr
);

	engine_pkg::kern_t kx_q;
	engine_pkg::kern_t ky_q;
	engine_pkg::side_t ox_q;
	engine_pkg::side_t oy_q;
	engine_pkg::side_t col_base_q;
	engine_pkg::addr_t row_base_q;
	engine_pkg::addr_t out_row_base_q;
	engine_pkg::addr_t out_idx_q;
	engine_pkg::kern_t kern_max;
	engine_pkg::side_t pos_max;
	engine_pkg::addr_t row_stride;
	engine_pkg::addr_t col_addr;
	logic kx_last;
	logic ky_last;
	logic ox_last;

	// Stride times input side as shifted adds
	function automatic engine_pkg::addr_t stride_rows(engine_pkg::kern_t s,
			engine_pkg::side_t n);
		engine_pkg::addr_t sum;
		sum = '0;
		for (int b = 0; b < engine_pkg::KERN_W; b++) begin
			if (s[b]) begin
				sum = sum + (engine_pkg::addr_t'(n) << b);
			end
		end
		return sum;
	endfunction

	assign kern_max = i_cmd.kernel - engine_pkg::kern_t'(1);
	assign pos_max = i_cmd.o_side - engine_pkg::side_t'(1);
	assign row_stride = stride_rows(i_cmd.stride, i_cmd.i_side);

	assign kx_last = kx_q == kern_max;
	assign ky_last = ky_q == kern_max;
	assign ox_last = ox_q == pos_max;
	assign o_kern_last = kx_last && ky_last;
	assign o_pos_last = ox_last && (oy_q == pos_max);

	assign col_addr = engine_pkg::addr_t'(col_base_q) + engine_pkg::addr_t'(kx_q);
	assign o_rd_addr = i_cmd.data_addr + row_base_q + col_addr;
	assign o_wr_addr = i_cmd.result_addr + out_idx_q;

	always_ff @(posedge clk) begin
		if (!i_rst_n || i_clear) begin
			kx_q <= '0;
			ky_q <= '0;
			ox_q <= '0;
			oy_q <= '0;
			col_base_q <= '0;
			row_base_q <= '0;
			out_row_base_q <= '0;
			out_idx_q <= '0;
		end else if (i_kern_step) begin
			if (kx_last) begin
				kx_q <= '0;
				if (ky_last) begin
					// Back to the top row of this window
					ky_q <= '0;
					row_base_q <= out_row_base_q;
				end else begin
					ky_q <= ky_q + 4'd1;
					row_base_q <= row_base_q + engine_pkg::addr_t'(i_cmd.i_side);
				end
			end else begin
				kx_q <= kx_q + 4'd1;
			end
		end else if (i_pos_step) begin
			out_idx_q <= out_idx_q + 30'd1;
			if (ox_last) begin
				ox_q <= '0;
				oy_q <= oy_q + 8'd1;
				col_base_q <= '0;
				out_row_base_q <= out_row_base_q + row_stride;
				row_base_q <= out_row_base_q + row_stride;
			end else begin
				ox_q <= ox_q + 8'd1;
				col_base_q <= col_base_q + engine_pkg::side_t'(i_cmd.stride);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pool_alu.sv ====
`default_nettype none

module pool_alu (
	input  wire                       clk,
	input  wire                       i_rst_n,
	input  wire engine_pkg::pool_op_e i_op,
	input  wire                       i_clear,
	input  wire                       i_load,
	input  wire engine_pkg::sample_t  i_sample,
	output engine_pkg::sample_t       o_result
);

	engine_pkg::acc_t acc_q;
	engine_pkg::acc_t sample_ext;
	logic first_q;

	assign sample_ext = engine_pkg::acc_t'(i_sample);

	// First load of a window replaces the accumulator
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			first_q <= 1'b1;
		end else if (i_clear) begin
			first_q <= 1'b1;
		end else if (i_load) begin
			first_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_load) begin
			if (first_q) begin
				acc_q <= sample_ext;
			end else if (i_op == engine_pkg::POOL_MAX) begin
				if (sample_ext > acc_q) begin
					acc_q <= sample_ext;
				end
			end else begin
				acc_q <= acc_q + sample_ext;
			end
		end
	end

	// Only the sum can saturate
	always_comb begin
		if (i_op == engine_pkg::POOL_MAX) begin
			o_result = engine_pkg::sample_t'(acc_q);
		end else if (acc_q > engine_pkg::acc_t'(engine_pkg::SAMPLE_MAX)) begin
			o_result = engine_pkg::SAMPLE_MAX;
		end else if (acc_q < engine_pkg::acc_t'(engine_pkg::SAMPLE_MIN)) begin
			o_result = engine_pkg::SAMPLE_MIN;
		end else begin
			o_result = engine_pkg::sample_t'(acc_q);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/result_port.sv ====
`default_nettype none

module result_port (
	input  wire                      clk,
	input  wire                      i_rst_n,
	input  wire                      i_load,
	input  wire engine_pkg::sample_t i_result,
	input  wire engine_pkg::addr_t   i_addr,
	input  wire                      i_wr_re,
	output logic                     o_wr_en,
	output engine_pkg::addr_t        o_wr_addr,
	output engine_pkg::sample_t      o_wr_data,
	output logic                     o_taken
);

	always_ff @(posedge clk) begin
		if (i_load) begin
			o_wr_addr <= i_addr;
			o_wr_data <= i_result;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_wr_en <= 1'b0;
		end else if (i_load) begin
			o_wr_en <= 1'b1;
		end else if (i_wr_re) begin
			o_wr_en <= 1'b0;
		end
	end

	// Accept only counts while a write is pending
	assign o_taken = o_wr_en && i_wr_re;

	a_wr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_wr_en && !i_wr_re |=> o_wr_en && $stable(o_wr_addr) && $stable(o_wr_data));

endmodule

`default_nettype wire

// ==== verilog/pool_engine_top.sv ====
`default_nettype none

module pool_engine_top (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire                          i_start,
	input  wire engine_pkg::engine_cmd_t i_cmd,
	output logic                         o_busy,
	output logic                         o_done,
	output logic                         o_rd_en,
	output engine_pkg::addr_t            o_rd_addr,
	input  wire                          i_rd_we,
	input  wire engine_pkg::sample_t     i_rd_data,
	output logic                         o_wr_en,
	output engine_pkg::addr_t            o_wr_addr,
	output engine_pkg::sample_t          o_wr_data,
	input  wire                          i_wr_re
);

	wire engine_pkg::engine_cmd_t cmd;
	wire engine_pkg::addr_t wr_addr;
	wire engine_pkg::sample_t result;
	wire cnt_clear;
	wire kern_step;
	wire pos_step;
	wire kern_last;
	wire pos_last;
	wire acc_clear;
	wire acc_load;
	wire res_load;
	wire res_taken;

	engine_ctrl engine_ctrl_inst (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_cmd       (i_cmd),
		.i_rd_we     (i_rd_we),
		.i_kern_last (kern_last),
		.i_pos_last  (pos_last),
		.i_res_taken (res_taken),
		.o_cmd       (cmd),
		.o_busy      (o_busy),
		.o_done      (o_done),
		.o_rd_en     (o_rd_en),
		.o_cnt_clear (cnt_clear),
		.o_kern_step (kern_step),
		.o_pos_step  (pos_step),
		.o_acc_clear (acc_clear),
		.o_acc_load  (acc_load),
		.o_res_load  (res_load)
	);

	window_counter window_counter_inst (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_cmd       (cmd),
		.i_clear     (cnt_clear),
		.i_kern_step (kern_step),
		.i_pos_step  (pos_step),
		.o_kern_last (kern_last),
		.o_pos_last  (pos_last),
		.o_rd_addr   (o_rd_addr),
		.o_wr_addr   (wr_addr)
	);

	pool_alu pool_alu_inst (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_op     (cmd.op),
		.i_clear  (acc_clear),
		.i_load   (acc_load),
		.i_sample (i_rd_data),
		.o_result (result)
	);

	result_port result_port_inst (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_load    (res_load),
		.i_result  (result),
		.i_addr    (wr_addr),
		.i_wr_re   (i_wr_re),
		.o_wr_en   (o_wr_en),
		.o_wr_addr (o_wr_addr),
		.o_wr_data (o_wr_data),
		.o_taken   (res_taken)
	);

endmodule

`default_nettype wire

// ==== dv/dma_model.sv ====
`default_nettype none

module dma_model (
	input  wire                      clk,
	input  wire                      i_rst_n,
	input  wire [7:0]                i_max_delay,
	input  wire                      i_rd_en,
	input  wire engine_pkg::addr_t   i_rd_addr,
	output logic                     o_rd_we,
	output engine_pkg::sample_t      o_rd_data,
	input  wire                      i_wr_en,
	input  wire engine_pkg::addr_t   i_wr_addr,
	input  wire engine_pkg::sample_t i_wr_data,
	output logic                     o_wr_re
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 4096;

	engine_pkg::sample_t mem [0:DEPTH-1];
	int seed;
	int rd_wait;
	int wr_wait;

	// Extra cycles beyond the minimum of one
	function automatic int next_delay();
		return $unsigned($random(seed)) % (int'(i_max_delay) + 1);
	endfunction

	task automatic store_word(input engine_pkg::addr_t a, input engine_pkg::sample_t v);
		mem[a[11:0]] = v;
	endtask

	function automatic engine_pkg::sample_t load_word(input engine_pkg::addr_t a);
		return mem[a[11:0]];
	endfunction

	initial begin
		seed = 31089;
		rd_wait = 0;
		wr_wait = 0;
		o_rd_we = 1'b0;
		o_rd_data = '0;
		o_wr_re = 1'b0;
		// Background pattern spans every address bit
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = engine_pkg::sample_t'(i ^ (i << 5));
		end
	end

	// One process for both ports keeps the random sequence fixed
	always @(negedge clk) begin
		if (!i_rst_n) begin
			o_rd_we <= 1'b0;
			o_wr_re <= 1'b0;
			rd_wait <= 0;
			wr_wait <= 0;
		end else begin
			if (o_rd_we || !i_rd_en) begin
				o_rd_we <= 1'b0;
			end else if (rd_wait == 0) begin
				o_rd_we <= 1'b1;
				o_rd_data <= load_word(i_rd_addr);
				rd_wait <= next_delay();
			end else begin
				rd_wait <= rd_wait - 1;
			end

			if (o_wr_re || !i_wr_en) begin
				o_wr_re <= 1'b0;
			end else if (wr_wait == 0) begin
				o_wr_re <= 1'b1;
				mem[i_wr_addr[11:0]] <= i_wr_data;
				wr_wait <= next_delay();
			end else begin
				wr_wait <= wr_wait - 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/pool_engine_tb.sv ====
`default_nettype none

module pool_engine_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int LOG_DEPTH = 256;

	logic clk;
	logic i_rst_n;
	logic i_start;
	engine_pkg::engine_cmd_t i_cmd;
	logic o_busy;
	logic o_done;
	logic o_rd_en;
	engine_pkg::addr_t o_rd_addr;
	logic rd_we;
	engine_pkg::sample_t rd_data;
	logic o_wr_en;
	engine_pkg::addr_t o_wr_addr;
	engine_pkg::sample_t o_wr_data;
	logic wr_re;
	logic [7:0] max_delay;

	// Mirror of the input maps for the reference model
	engine_pkg::sample_t shadow [0:4095];
	engine_pkg::addr_t wr_log [0:LOG_DEPTH-1];
	int wr_count;
	int done_count;
	int seed;

	logic rd_pend_q;
	engine_pkg::addr_t rd_addr_q;
	logic wr_pend_q;
	engine_pkg::addr_t wr_addr_q;
	engine_pkg::sample_t wr_data_q;

	pool_engine_top pool_engine_top_inst (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_start   (i_start),
		.i_cmd     (i_cmd),
		.o_busy    (o_busy),
		.o_done    (o_done),
		.o_rd_en   (o_rd_en),
		.o_rd_addr (o_rd_addr),
		.i_rd_we   (rd_we),
		.i_rd_data (rd_data),
		.o_wr_en   (o_wr_en),
		.o_wr_addr (o_wr_addr),
		.o_wr_data (o_wr_data),
		.i_wr_re   (wr_re)
	);

	dma_model dma_model_inst (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_max_delay (max_delay),
		.i_rd_en     (o_rd_en),
		.i_rd_addr   (o_rd_addr),
		.o_rd_we     (rd_we),
		.o_rd_data   (rd_data),
		.i_wr_en     (o_wr_en),
		.i_wr_addr   (o_wr_addr),
		.i_wr_data   (o_wr_data),
		.o_wr_re     (wr_re)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input engine_pkg::addr_t got,
			input engine_pkg::addr_t exp);
		if (got !== exp) begin
			fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_sample(input string name, input engine_pkg::sample_t got,
			input engine_pkg::sample_t exp);
		if (got !== exp) begin
			fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Held requests must keep their address and data
	always @(posedge clk) begin
		if (!i_rst_n) begin
			rd_pend_q = 1'b0;
			wr_pend_q = 1'b0;
		end else begin
			if (rd_pend_q) begin
				check_level("o_rd_en", o_rd_en, 1'b1);
				check_addr("o_rd_addr", o_rd_addr, rd_addr_q);
			end
			if (wr_pend_q) begin
				check_level("o_wr_en", o_wr_en, 1'b1);
				check_addr("o_wr_addr", o_wr_addr, wr_addr_q);
				check_sample("o_wr_data", o_wr_data, wr_data_q);
			end
			if (o_wr_en && wr_re) begin
				if (wr_count < LOG_DEPTH) begin
					wr_log[wr_count] = o_wr_addr;
				end
				wr_count++;
			end
			if (o_done) begin
				done_count++;
			end
			rd_pend_q = o_rd_en && !rd_we;
			rd_addr_q = o_rd_addr;
			wr_pend_q = o_wr_en && !wr_re;
			wr_addr_q = o_wr_addr;
			wr_data_q = o_wr_data;
		end
	end

	function automatic engine_pkg::engine_cmd_t make_cmd(input engine_pkg::pool_op_e op,
			input int side, input int kernel, input int stride, input int data_addr,
			input int result_addr);
		engine_pkg::engine_cmd_t c;
		c.op = op;
		c.i_side = engine_pkg::side_t'(side);
		c.o_side = engine_pkg::side_t'((side - kernel) / stride + 1);
		c.kernel = engine_pkg::kern_t'(kernel);
		c.stride = engine_pkg::kern_t'(stride);
		c.data_addr = engine_pkg::addr_t'(data_addr);
		c.result_addr = engine_pkg::addr_t'(result_addr);
		return c;
	endfunction

	// Window max, or sum clipped to the sample range
	function automatic engine_pkg::sample_t pool_ref(input engine_pkg::engine_cmd_t c,
			input int ox, input int oy);
		int acc;
		int v;
		int idx;
		acc = 0;
		for (int ky = 0; ky < int'(c.kernel); ky++) begin
			for (int kx = 0; kx < int'(c.kernel); kx++) begin
				idx = int'(c.data_addr) + (oy * int'(c.stride) + ky) * int'(c.i_side)
					+ ox * int'(c.stride) + kx;
				v = shadow[idx];
				if (c.op == engine_pkg::POOL_SUM) begin
					acc = acc + v;
				end else if ((kx == 0 && ky == 0) || v > acc) begin
					acc = v;
				end
			end
		end
		if (acc > int'(engine_pkg::SAMPLE_MAX)) begin
			acc = int'(engine_pkg::SAMPLE_MAX);
		end else if (acc < int'(engine_pkg::SAMPLE_MIN)) begin
			acc = int'(engine_pkg::SAMPLE_MIN);
		end
		return engine_pkg::sample_t'(acc);
	endfunction

	task automatic store_sample(input engine_pkg::addr_t a, input engine_pkg::sample_t v);
		shadow[a[11:0]] = v;
		dma_model_inst.store_word(a, v);
	endtask

	// A range of zero means full 16-bit values
	task automatic fill_random(input engine_pkg::engine_cmd_t c, input int range);
		int v;
		for (int i = 0; i < int'(c.i_side) * int'(c.i_side); i++) begin
			if (range > 0) begin
				v = $random(seed) % range;
			end else begin
				v = $random(seed);
			end
			store_sample(c.data_addr + engine_pkg::addr_t'(i), engine_pkg::sample_t'(v));
		end
	endtask

	task automatic run_command(input engine_pkg::engine_cmd_t cmd);
		int wr_base;
		int done_base;
		int n_out;
		int cycles;
		engine_pkg::addr_t a;
		wr_base = wr_count;
		done_base = done_count;
		check_level("o_busy", o_busy, 1'b0);
		i_cmd = cmd;
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		check_level("o_busy", o_busy, 1'b1);
		cycles = 0;
		while (!o_done) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				fail_run("Timed out waiting for o_done");
			end
		end
		// Let the FSM return to idle
		@(negedge clk);
		n_out = int'(cmd.o_side) * int'(cmd.o_side);
		if (wr_count - wr_base != n_out) begin
			fail_run("Number of result writes does not match the output size");
		end
		if (done_count - done_base != 1) begin
			fail_run("Command did not give exactly one done pulse");
		end
		for (int i = 0; i < n_out; i++) begin
			a = cmd.result_addr + engine_pkg::addr_t'(i);
			check_addr("o_wr_addr", wr_log[wr_base + i], a);
			check_sample("o_wr_data", dma_model_inst.load_word(a),
				pool_ref(cmd, i % int'(cmd.o_side), i / int'(cmd.o_side)));
		end
	endtask

	task automatic reset_state_is_idle();
		check_level("o_busy", o_busy, 1'b0);
		check_level("o_done", o_done, 1'b0);
		check_level("o_rd_en", o_rd_en, 1'b0);
		check_level("o_wr_en", o_wr_en, 1'b0);
	endtask

	task automatic max_pool_3x3();
		engine_pkg::engine_cmd_t c;
		max_delay = 8'd2;
		c = make_cmd(engine_pkg::POOL_MAX, 7, 3, 2, 'h100, 'h400);
		fill_random(c, 0);
		run_command(c);
	endtask

	task automatic sum_pool_small();
		engine_pkg::engine_cmd_t c;
		max_delay = 8'd2;
		c = make_cmd(engine_pkg::POOL_SUM, 6, 2, 2, 'h180, 'h440);
		fill_random(c, 101);
		run_command(c);
	endtask

	task automatic sum_pool_saturates();
		engine_pkg::engine_cmd_t c;
		int v;
		c = make_cmd(engine_pkg::POOL_SUM, 4, 2, 2, 'h1c0, 'h480);
		// Quadrants overflow high, low, stay small, land just under the limit
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 4; x++) begin
				if (y < 2) begin
					v = (x < 2) ? 20000 : -20000;
				end else begin
					v = (x < 2) ? 10 + x : 8191;
				end
				store_sample(c.data_addr + engine_pkg::addr_t'(y * 4 + x),
					engine_pkg::sample_t'(v));
			end
		end
		run_command(c);
	endtask

	task automatic slow_dma_max_pool();
		engine_pkg::engine_cmd_t c;
		max_delay = 8'd12;
		c = make_cmd(engine_pkg::POOL_MAX, 5, 2, 1, 'h200, 'h4c0);
		fill_random(c, 0);
		run_command(c);
		max_delay = 8'd2;
	endtask

	task automatic back_to_back_commands();
		engine_pkg::engine_cmd_t first;
		engine_pkg::engine_cmd_t second;
		first = make_cmd(engine_pkg::POOL_SUM, 4, 2, 2, 'h240, 'h500);
		second = make_cmd(engine_pkg::POOL_MAX, 6, 3, 3, 'h260, 'h520);
		fill_random(first, 1000);
		fill_random(second, 0);
		run_command(first);
		run_command(second);
	endtask

	initial begin
		seed = 31089;
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_start = 1'b0;
		i_cmd = '0;
		max_delay = 8'd2;
		wr_count = 0;
		done_count = 0;
		repeat (8) @(negedge clk);
		i_rst_n = 1'b1;
		@(negedge clk);
		reset_state_is_idle();
		max_pool_3x3();
		sum_pool_small();
		sum_pool_saturates();
		slow_dma_max_pool();
		back_to_back_commands();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/engine_pkg.sv
verilog/engine_ctrl.sv
verilog/window_counter.sv
verilog/pool_alu.sv
verilog/result_port.sv
verilog/pool_engine_top.sv
dv/dma_model.sv
dv/pool_engine_tb.sv
